/* bench/synth_voice_tb.sv */
`timescale 1ns/1ps

module synth_voice_tb;
	import synth_pkg::*;

	localparam int RAND_SEGS    = 40;
	localparam int RESET_CYCLES = 2;

	logic               clk50mhz;
	logic               rst;
	logic [NOTE_W-1:0]  note_in;
	logic               gate;
	logic [DEPTH_W-1:0] depth;
	logic [NOTE_W-1:0]  glide_note;
	logic [NOTE_W-1:0]  pitch;
	logic               tone_out;

	// stimulus segments each held for seg_len cycles
	string seg_name[$];
	int    seg_note[$];
	int    seg_gate[$];
	int    seg_depth[$];
	int    seg_len[$];

	// model of tickers, note history, glide, lfo and pitch
	int g_cnt, l_cnt;
	int m_cur, m_prev, m_start, m_glide, m_ofs, m_pitch;
	// pitch register seen by the oscillator in the last cycle
	int m_pitch_used;
	bit m_armed, m_up;

	// tone edge tracking
	logic last_tone;
	bit   tone_valid;
	int   tone_count, tone_exp, tone_oct;
	int   tone_hits[6];

	int cycle_count;
	int cycle_limit;

	synth_voice_top dut (
		.clk50mhz   (clk50mhz),
		.rst        (rst),
		.note_in    (note_in),
		.gate       (gate),
		.depth      (depth),
		.glide_note (glide_note),
		.pitch      (pitch),
		.tone_out   (tone_out)
	);

	always #10 clk50mhz = ~clk50mhz;

	task automatic abort_run();
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected)
		begin
			$display("MISMATCH %s expected %0d actual %0d", name, expected, actual);
			abort_run();
		end
	endtask

	// table entry for the semitone doubled once per octave below the top
	function automatic int half_period_of(input int note);
		int base;
		base = HALF_PERIOD_TOP[note % SEMITONES];
		return base << (TOP_OCT - note / SEMITONES);
	endfunction

	function automatic int dist_of(input int a, input int b);
		return (a > b) ? (a - b) : (b - a);
	endfunction

	task automatic add_segment(input string name, input int note, input int gate_v,
		input int depth_v, input int len);
		seg_name.push_back(name);
		seg_note.push_back(note);
		seg_gate.push_back(gate_v);
		seg_depth.push_back(depth_v);
		seg_len.push_back(len);
	endtask

	// one clock of the reference model with inputs stable here
	task automatic update_model();
		bit g_tick, l_tick;
		int nxt_glide, nxt_pitch, sum, ival, stp, lim;
		bit nxt_armed;
		m_pitch_used = rst ? 0 : m_pitch;
		if (rst)
		begin
			g_cnt = 0;
			l_cnt = 0;
			m_cur = 0;
			m_prev = 0;
			m_start = 0;
			m_glide = 0;
			m_ofs = 0;
			m_pitch = 0;
			m_armed = 0;
			m_up = 1;
		end
		else
		begin
			g_tick = (g_cnt == GLIDE_DIV - 1);
			l_tick = (l_cnt == LFO_DIV - 1);
			// pitch from last cycle's glide and offset where rest stays rest
			if (m_glide == 0)
				nxt_pitch = 0;
			else
			begin
				sum = m_glide + m_ofs;
				nxt_pitch = (sum < 1) ? 1 : ((sum > 63) ? 63 : sum);
			end
			nxt_glide = m_glide;
			nxt_armed = m_armed;
			if (!gate)
			begin
				nxt_glide = 0;
				nxt_armed = 0;
			end
			else if (g_tick)
			begin
				if (!m_armed)
				begin
					// first tick after gate rise takes the registered note
					nxt_glide = m_cur;
					nxt_armed = 1;
				end
				else
				begin
					ival = dist_of(note_in, m_start);
					stp = (ival > 4) ? ival / 4 : 1;
					if (dist_of(note_in, m_glide) < stp)
						nxt_glide = note_in;
					else if (m_glide < note_in)
						nxt_glide = m_glide + stp;
					else
						nxt_glide = m_glide - stp;
				end
			end
			// note history
			if (m_cur != m_prev)
				m_start = m_prev;
			m_prev = m_cur;
			m_cur = note_in;
			// triangle lfo
			if (l_tick)
			begin
				lim = depth;
				if (m_ofs > lim || m_ofs < -lim)
				begin
					// shrunk depth heads back toward zero
					m_up = (m_ofs < 0);
					m_ofs = m_up ? m_ofs + 1 : m_ofs - 1;
				end
				else if (lim > 0)
				begin
					if (m_up && m_ofs == lim)
						m_up = 0;
					else if (!m_up && m_ofs == -lim)
						m_up = 1;
					m_ofs = m_up ? m_ofs + 1 : m_ofs - 1;
				end
			end
			g_cnt = g_tick ? 0 : g_cnt + 1;
			l_cnt = l_tick ? 0 : l_cnt + 1;
			m_glide = nxt_glide;
			m_armed = nxt_armed;
			m_pitch = nxt_pitch;
		end
	endtask

	always @(posedge clk50mhz)
		update_model();

	// compare outputs and time the tone half periods
	task automatic check_outputs(input string name);
		check_value({name, " glide_note"}, m_glide, glide_note);
		check_value({name, " pitch"}, m_pitch, pitch);
		if (m_pitch_used == 0)
		begin
			check_value({name, " tone_out at rest"}, 0, tone_out);
			tone_valid = 0;
			tone_count = 0;
		end
		else
		begin
			tone_count++;
			if (tone_out !== last_tone)
			begin
				if (tone_valid)
				begin
					check_value({name, " half period"}, tone_exp, tone_count);
					tone_hits[tone_oct]++;
				end
				// next half period comes from the pitch at this toggle
				tone_exp = half_period_of(m_pitch_used);
				tone_oct = m_pitch_used / SEMITONES;
				tone_valid = 1;
				tone_count = 0;
			end
		end
		last_tone = tone_out;
	endtask

	// watchdog
	always @(posedge clk50mhz)
	begin
		cycle_count++;
		if (cycle_count > cycle_limit)
		begin
			$display("timeout: stimulus did not finish");
			abort_run();
		end
	end

	initial
	begin
		int total;
		int hp;
		int missing;
		int tone_notes[6];
		clk50mhz = 0;
		rst = 1;
		note_in = '0;
		gate = 0;
		depth = '0;
		last_tone = 0;
		cycle_count = 0;
		tone_valid = 0;
		tone_count = 0;
		void'($urandom(54));
		// gate low and then the first tick loads the note
		add_segment("gate_timing", 40, 0, 2, 300);
		add_segment("gate_timing", 40, 1, 0, 400);
		// wide jumps in quarter steps in both directions
		add_segment("glide_down", 10, 1, 0, 600);
		add_segment("glide_up", 50, 1, 0, 800);
		add_segment("glide_down", 12, 1, 0, 800);
		// narrow jumps in semitones
		add_segment("glide_small_up", 15, 1, 0, 400);
		add_segment("glide_small_down", 11, 1, 0, 400);
		// depth sweep where 3 to 1 cuts the triangle short
		add_segment("vibrato", 30, 1, 3, 1500);
		add_segment("vibrato", 30, 1, 1, 700);
		add_segment("vibrato", 30, 1, 2, 800);
		add_segment("vibrato", 30, 1, 0, 500);
		add_segment("clamp_low", 1, 1, 3, 1500);
		add_segment("clamp_low", 2, 1, 3, 1000);
		add_segment("clamp_high", 63, 1, 3, 1500);
		add_segment("clamp_high", 61, 1, 3, 1000);
		add_segment("rest", 61, 0, 3, 300);
		for (int i = 0; i < RAND_SEGS; i++)
		begin
			add_segment("random", 1 + $urandom % 63, ($urandom % 5) != 0, $urandom % 4,
				200 + $urandom % 2801);
		end
		// one note per octave with a rest first to restart the oscillator
		tone_notes = '{11, 23, 35, 47, 59, 62};
		foreach (tone_notes[k])
		begin
			hp = half_period_of(tone_notes[k]);
			add_segment($sformatf("tone_oct%0d", k), tone_notes[k], 0, 0, 400);
			add_segment($sformatf("tone_oct%0d", k), tone_notes[k], 1, 0,
				2 * hp + hp / 2 + 300);
		end
		total = RESET_CYCLES;
		foreach (seg_len[i])
			total += seg_len[i];
		cycle_limit = total + total / 10;
		repeat (RESET_CYCLES) @(posedge clk50mhz);
		@(negedge clk50mhz);
		rst = 0;
		foreach (seg_len[i])
		begin
			note_in = NOTE_W'(seg_note[i]);
			gate = seg_gate[i][0];
			depth = DEPTH_W'(seg_depth[i]);
			repeat (seg_len[i])
			begin
				@(negedge clk50mhz);
				check_outputs(seg_name[i]);
			end
		end
		missing = -1;
		foreach (tone_hits[o])
		begin
			if (tone_hits[o] == 0)
				missing = o;
		end
		if (missing >= 0)
		begin
			$display("no tone half period was measured in octave %0d", missing);
			abort_run();
		end
		else
		begin
			$display("Test passed");
			$finish;
		end
	end

endmodule

/* flist.f */
hw/synth_pkg.sv
hw/rate_ticker.sv
hw/note_glide.sv
hw/vibrato_lfo.sv
hw/tone_osc.sv
hw/synth_voice_top.sv
bench/synth_voice_tb.sv

/* hw/note_glide.sv */
`timescale 1ns/1ps

module note_glide (
	input  logic                         clk50mhz,
	input  logic                         rst,
	input  logic [synth_pkg::NOTE_W-1:0] note_in,
	input  logic                         gate,
	input  logic                         glide_tick,
	output logic [synth_pkg::NOTE_W-1:0] glide_note
);
	import synth_pkg::*;

	// registered input note and the stage behind it
	logic [NOTE_W-1:0] cur_note;
	logic [NOTE_W-1:0] prev_note;
	// note the glide started from
	logic [NOTE_W-1:0] start_note;
	// set once the first tick after gate rise has loaded a note
	logic              armed;

	// full interval of the current glide
	logic [NOTE_W-1:0] interval;
	// distance still left to the target
	logic [NOTE_W-1:0] remain;
	logic [NOTE_W-1:0] step;
	logic              going_up;

	// two stage note history
	always_ff @(posedge clk50mhz)
	begin
		if (rst)
		begin
			cur_note   <= '0;
			prev_note  <= '0;
			start_note <= '0;
		end
		else
		begin
			cur_note  <= note_in;
			prev_note <= cur_note;
			// a new note arrived so remember where we came from
			if (cur_note != prev_note)
			begin
				start_note <= prev_note;
			end
		end
	end

	// size of the jump being glided over
	assign interval = (start_note > note_in) ? (start_note - note_in)
	                                         : (note_in - start_note);

	// quarter steps for wide jumps and semitones for narrow ones
	assign step = (interval > GLIDE_SMALL) ? (interval >> 2) : NOTE_W'(1);

	// direction taken from where the output is now
	assign going_up = (glide_note < note_in);
	assign remain   = going_up ? (note_in - glide_note) : (glide_note - note_in);

	// portamento output cleared on any clock while gate is low
	always_ff @(posedge clk50mhz)
	begin
		if (rst || !gate)
		begin
			glide_note <= '0;
			armed      <= 1'b0;
		end
		else if (glide_tick)
		begin
			if (!armed)
			begin
				// first tick after gate rise jumps straight to the note
				glide_note <= cur_note;
				armed      <= 1'b1;
			end
			else if (remain < step)
			begin
				// close enough so land exactly without overshoot
				glide_note <= note_in;
			end
			else if (going_up)
			begin
				glide_note <= glide_note + step;
			end
			else
			begin
				glide_note <= glide_note - step;
			end
		end
	end

endmodule

/* hw/rate_ticker.sv */
`timescale 1ns/1ps

module rate_ticker #(
	parameter int DIVISOR = 64
) (
	input  logic clk50mhz,
	input  logic rst,
	output logic tick
);

	// at least one bit even for tiny divisors
	localparam int CNT_W = (DIVISOR > 1) ? $clog2(DIVISOR) : 1;

	logic [CNT_W-1:0] count;
	logic             at_wrap;

	// last count of the period
	assign at_wrap = (count == CNT_W'(DIVISOR - 1));

	// free running and wraps back to 0 after DIVISOR-1
	always_ff @(posedge clk50mhz)
	begin
		if (rst)
		begin
			count <= '0;
		end
		else if (at_wrap)
		begin
			count <= '0;
		end
		else
		begin
			count <= count + 1'b1;
		end
	end

	// one cycle strobe per period
	assign tick = at_wrap;

endmodule

/* hw/synth_pkg.sv */
package synth_pkg;

	// note number where 0 means rest
	localparam int NOTE_W = 6;
	// playable note range
	localparam int MIN_NOTE = 1;
	localparam int MAX_NOTE = (1 << NOTE_W) - 1;

	// signed vibrato offset in semitones
	localparam int OFS_W = 3;
	// largest offset magnitude the lfo may reach
	localparam int OFS_MAX = (1 << (OFS_W - 1)) - 1;
	// vibrato depth select of 0..3 semitones
	localparam int DEPTH_W = 2;

	// intervals up to this use single semitone steps
	localparam int GLIDE_SMALL = 4;

	// clocks between glide steps kept short for simulation
	localparam int GLIDE_DIV = 64;
	// clocks between lfo steps
	localparam int LFO_DIV = 96;

	// half-period counter width
	localparam int HP_W = 20;
	localparam int SEMITONES = 12;
	// octave of notes 60..71 which need no shift
	localparam int TOP_OCT = 5;

	// half periods at 50 MHz for notes 60..71
	// lower octaves shift these left by (TOP_OCT - octave)
	localparam logic [0:SEMITONES-1][HP_W-1:0] HALF_PERIOD_TOP = {
		20'd11945,
		20'd11274,
		20'd10641,
		20'd10044,
		20'd9480,
		20'd8948,
		20'd8446,
		20'd7972,
		20'd7525,
		20'd7102,
		20'd6704,
		20'd6327
	};

endpackage

/* hw/synth_voice_top.sv */
`timescale 1ns/1ps

module synth_voice_top (
	input  logic                          clk50mhz,
	input  logic                          rst,
	input  logic [synth_pkg::NOTE_W-1:0]  note_in,
	input  logic                          gate,
	input  logic [synth_pkg::DEPTH_W-1:0] depth,
	output logic [synth_pkg::NOTE_W-1:0]  glide_note,
	output logic [synth_pkg::NOTE_W-1:0]  pitch,
	output logic                          tone_out
);
	import synth_pkg::*;

	// step strobes for glide and lfo
	logic                    glide_tick;
	logic                    lfo_tick;
	// triangle offset into the oscillator
	logic signed [OFS_W-1:0] vib_offset;

	// glide rate
	rate_ticker #(
		.DIVISOR (GLIDE_DIV)
	) u_glide_tick (
		.clk50mhz (clk50mhz),
		.rst      (rst),
		.tick     (glide_tick)
	);

	// vibrato rate
	rate_ticker #(
		.DIVISOR (LFO_DIV)
	) u_lfo_tick (
		.clk50mhz (clk50mhz),
		.rst      (rst),
		.tick     (lfo_tick)
	);

	// portamento
	note_glide u_note_glide (
		.clk50mhz   (clk50mhz),
		.rst        (rst),
		.note_in    (note_in),
		.gate       (gate),
		.glide_tick (glide_tick),
		.glide_note (glide_note)
	);

	// runs alongside the glide
	vibrato_lfo u_vibrato_lfo (
		.clk50mhz   (clk50mhz),
		.rst        (rst),
		.lfo_tick   (lfo_tick),
		.depth      (depth),
		.vib_offset (vib_offset)
	);

	// pitch and square wave out
	tone_osc u_tone_osc (
		.clk50mhz   (clk50mhz),
		.rst        (rst),
		.glide_note (glide_note),
		.vib_offset (vib_offset),
		.pitch      (pitch),
		.tone_out   (tone_out)
	);

endmodule

/* hw/tone_osc.sv */
`timescale 1ns/1ps

module tone_osc (
	input  logic                               clk50mhz,
	input  logic                               rst,
	input  logic [synth_pkg::NOTE_W-1:0]       glide_note,
	input  logic signed [synth_pkg::OFS_W-1:0] vib_offset,
	output logic [synth_pkg::NOTE_W-1:0]       pitch,
	output logic                               tone_out
);
	import synth_pkg::*;

	// two extra bits keep sign and carry of the sum
	logic signed [NOTE_W+1:0] pitch_sum;
	logic [NOTE_W-1:0]        pitch_next;

	// pitch split into octave and semitone
	logic [2:0]               octave;
	logic [3:0]               semi;
	logic [HP_W-1:0]          half_period;

	// half period held since the last toggle and 0 while idle
	logic [HP_W-1:0]          hp_latch;
	logic [HP_W-1:0]          hp_limit;
	logic [HP_W-1:0]          hp_cnt;

	// glided note plus signed vibrato
	assign pitch_sum = $signed({2'b00, glide_note}) + vib_offset;

	always_comb
	begin
		if (glide_note == '0)
		begin
			// rest stays rest whatever the lfo does
			pitch_next = '0;
		end
		else if (pitch_sum < MIN_NOTE)
		begin
			pitch_next = NOTE_W'(MIN_NOTE);
		end
		else if (pitch_sum > MAX_NOTE)
		begin
			pitch_next = NOTE_W'(MAX_NOTE);
		end
		else
		begin
			pitch_next = pitch_sum[NOTE_W-1:0];
		end
	end

	always_ff @(posedge clk50mhz)
	begin
		if (rst)
		begin
			pitch <= '0;
		end
		else
		begin
			pitch <= pitch_next;
		end
	end

	// octave lookup with the highest octave first
	always_comb
	begin
		if (pitch >= NOTE_W'(TOP_OCT * SEMITONES))
		begin
			octave = 3'(TOP_OCT);
			semi   = 4'(pitch - NOTE_W'(TOP_OCT * SEMITONES));
		end
		else if (pitch >= NOTE_W'((TOP_OCT - 1) * SEMITONES))
		begin
			octave = 3'(TOP_OCT - 1);
			semi   = 4'(pitch - NOTE_W'((TOP_OCT - 1) * SEMITONES));
		end
		else if (pitch >= NOTE_W'((TOP_OCT - 2) * SEMITONES))
		begin
			octave = 3'(TOP_OCT - 2);
			semi   = 4'(pitch - NOTE_W'((TOP_OCT - 2) * SEMITONES));
		end
		else if (pitch >= NOTE_W'((TOP_OCT - 3) * SEMITONES))
		begin
			octave = 3'(TOP_OCT - 3);
			semi   = 4'(pitch - NOTE_W'((TOP_OCT - 3) * SEMITONES));
		end
		else if (pitch >= NOTE_W'(SEMITONES))
		begin
			octave = 3'd1;
			semi   = 4'(pitch - NOTE_W'(SEMITONES));
		end
		else
		begin
			octave = 3'd0;
			semi   = 4'(pitch);
		end
	end

	// each octave down doubles the half period
	assign half_period = HALF_PERIOD_TOP[semi] << (TOP_OCT - octave);

	// first half period after a rest uses the live lookup
	assign hp_limit = (hp_latch == '0) ? half_period : hp_latch;

	always_ff @(posedge clk50mhz)
	begin
		if (rst || pitch == '0)
		begin
			hp_cnt   <= '0;
			hp_latch <= '0;
			tone_out <= 1'b0;
		end
		else if (hp_cnt == hp_limit - 1'b1)
		begin
			// edge reloads from the pitch playing right now
			hp_cnt   <= '0;
			hp_latch <= half_period;
			tone_out <= ~tone_out;
		end
		else
		begin
			hp_cnt   <= hp_cnt + 1'b1;
			hp_latch <= hp_limit;
		end
	end

endmodule

/* hw/vibrato_lfo.sv */
`timescale 1ns/1ps

module vibrato_lfo (
	input  logic                               clk50mhz,
	input  logic                               rst,
	input  logic                               lfo_tick,
	input  logic [synth_pkg::DEPTH_W-1:0]      depth,
	output logic signed [synth_pkg::OFS_W-1:0] vib_offset
);
	import synth_pkg::*;

	// turning point of the triangle
	logic signed [OFS_W-1:0] lim;
	// 1 while climbing toward +lim
	logic                    dir_up;
	// depth dropped under the present magnitude
	logic                    out_of_range;

	// depth capped to what the offset width can hold
	assign lim = (depth > OFS_MAX) ? OFS_W'(OFS_MAX) : OFS_W'(depth);

	assign out_of_range = (vib_offset > lim) || (vib_offset < -lim);

	always_ff @(posedge clk50mhz)
	begin
		if (rst)
		begin
			vib_offset <= '0;
			dir_up     <= 1'b1;
		end
		else if (lfo_tick)
		begin
			if (out_of_range)
			begin
				// walk back toward zero one step per tick
				// direction follows so the triangle carries on smoothly
				if (vib_offset > 0)
				begin
					vib_offset <= vib_offset - OFS_W'(1);
					dir_up     <= 1'b0;
				end
				else
				begin
					vib_offset <= vib_offset + OFS_W'(1);
					dir_up     <= 1'b1;
				end
			end
			else if (lim == '0)
			begin
				// depth 0 means no vibrato
				vib_offset <= '0;
			end
			else if (dir_up)
			begin
				// top reached so turn down
				if (vib_offset == lim)
				begin
					vib_offset <= vib_offset - OFS_W'(1);
					dir_up     <= 1'b0;
				end
				else
				begin
					vib_offset <= vib_offset + OFS_W'(1);
				end
			end
			else
			begin
				// bottom reached so turn up
				if (vib_offset == -lim)
				begin
					vib_offset <= vib_offset + OFS_W'(1);
					dir_up     <= 1'b1;
				end
				else
				begin
					vib_offset <= vib_offset - OFS_W'(1);
				end
			end
		end
	end

endmodule
